//--- hdl/beat_counter.sv
// Beat counter for the instruction being collected
// Flags the final expected beat from the count and the last index

`timescale 1ns/1ps
`default_nettype none

module beat_counter import ccu_pkg::*; #(
    parameter int MAX_LEN = MAX_BEATS
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 clear_i,
    input  logic                 step_i,
    // Index of the final beat, the length minus one
    input  logic [CNT_WIDTH-1:0] len_i,
    output logic [CNT_WIDTH-1:0] count_o,
    output logic                 last_beat_o
);

    logic [CNT_WIDTH-1:0] count_q;

    // Clear wins over step
    always_ff @(posedge clk) begin
        if (reset_i || clear_i) begin
            count_q <= '0;
        end else if (step_i) begin
            count_q <= count_q + CNT_WIDTH'(1);
        end
    end

    assign count_o     = count_q;
    assign last_beat_o = (count_q == len_i);

    // The FSM must stop stepping on the final beat of any instruction
    a_count_range: assert property (
        @(posedge clk) disable iff (reset_i)
        (step_i && !clear_i) |-> int'(count_q) < MAX_LEN - 1
    );

endmodule

`default_nettype wire

//--- hdl/ccu_fsm.sv
// Control FSM of the configuration unit
// Accepts host beats, checks the length against last,
// raises the sticky error and drives the engine valid lines

`timescale 1ns/1ps
`default_nettype none

module ccu_fsm import ccu_pkg::*; #(
    parameter int GIC_LEN = GIC_BEATS,
    parameter int FPS_LEN = FPS_BEATS,
    parameter int KNN_LEN = KNN_BEATS
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic [PORT_WIDTH-1:0] isa_dat_i,
    input  logic                  isa_vld_i,
    input  logic                  isa_last_i,
    output logic                  isa_rdy_o,
    output logic [NUM_ENGINE-1:0] cfg_vld_o,
    input  logic [NUM_ENGINE-1:0] cfg_rdy_i,
    input  logic                  last_beat_i,
    input  opcode_e               target_i,
    output logic                  cnt_clear_o,
    output logic                  cnt_step_o,
    output logic [CNT_WIDTH-1:0]  beat_len_o,
    output logic                  err_o,
    output logic [1:0]            mon_state_o,
    isa_if.ctrl                   isa
);

    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_COLLECT  = 2'd1;
    localparam logic [1:0] ST_DISPATCH = 2'd2;
    localparam logic [1:0] ST_DRAIN    = 2'd3;

    // Final beat index per engine
    localparam logic [CNT_WIDTH-1:0] GIC_LAST = CNT_WIDTH'(GIC_LEN - 1);
    localparam logic [CNT_WIDTH-1:0] FPS_LAST = CNT_WIDTH'(FPS_LEN - 1);
    localparam logic [CNT_WIDTH-1:0] KNN_LAST = CNT_WIDTH'(KNN_LEN - 1);

    logic [1:0]           state_q;
    logic [1:0]           state_d;
    logic [CNT_WIDTH-1:0] len_q;
    logic [CNT_WIDTH-1:0] dec_len;
    logic                 err_q;
    logic                 fault;
    logic                 accept;
    logic                 bad_op;
    logic                 ending;
    logic                 dispatch_done;
    isa_beat_u            in_beat;

    assign in_beat.raw = isa_dat_i;
    assign bad_op      = (in_beat.hdr.opcode == OP_BAD);
    assign isa_rdy_o   = (state_q != ST_DISPATCH);
    assign accept      = isa_vld_i && isa_rdy_o;

    // ============================================================
    // Length decode from the header of the first beat
    // ============================================================
    always_comb begin
        case (in_beat.hdr.opcode)
            OP_GIC:  dec_len = GIC_LAST;
            OP_FPS:  dec_len = FPS_LAST;
            OP_KNN:  dec_len = KNN_LAST;
            default: dec_len = '0;
        endcase
    end

    // The counter sees the live decode while the first beat is on the bus
    assign beat_len_o = (state_q == ST_IDLE) ? dec_len : len_q;

    // Any beat that closes or aborts an instruction resets the count
    assign ending = accept && (isa_last_i || last_beat_i || state_q == ST_DRAIN
                               || (state_q == ST_IDLE && bad_op));
    assign cnt_clear_o = ending;
    assign cnt_step_o  = accept && !ending;

    // ============================================================
    // Next state
    // ============================================================
    always_comb begin
        state_d = state_q;
        fault   = 1'b0;
        case (state_q)
            ST_IDLE, ST_COLLECT: begin
                if (accept) begin
                    if (state_q == ST_IDLE && bad_op) begin
                        fault   = 1'b1;
                        state_d = isa_last_i ? ST_IDLE : ST_DRAIN;
                    end else if (last_beat_i && isa_last_i) begin
                        state_d = ST_DISPATCH;
                    end else if (last_beat_i) begin
                        // Expected final beat without last, host sends more
                        fault   = 1'b1;
                        state_d = ST_DRAIN;
                    end else if (isa_last_i) begin
                        fault   = 1'b1;
                        state_d = ST_IDLE;
                    end else begin
                        state_d = ST_COLLECT;
                    end
                end
            end
            ST_DISPATCH: begin
                if (dispatch_done) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                if (accept && isa_last_i) begin
                    state_d = ST_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            len_q   <= '0;
            err_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept && state_q == ST_IDLE) begin
                len_q <= dec_len;
            end
            if (fault) begin
                err_q <= 1'b1;
            end
        end
    end

    // ============================================================
    // Engine dispatch
    // ============================================================
    always_comb begin
        cfg_vld_o = '0;
        if (state_q == ST_DISPATCH) begin
            case (target_i)
                OP_GIC:  cfg_vld_o[0] = 1'b1;
                OP_FPS:  cfg_vld_o[1] = 1'b1;
                OP_KNN:  cfg_vld_o[2] = 1'b1;
                default: cfg_vld_o    = '0;
            endcase
        end
    end

    assign dispatch_done = |(cfg_vld_o & cfg_rdy_i);

    assign isa.accept        = accept;
    assign isa.first         = (state_q == ST_IDLE);
    assign isa.beat          = in_beat;
    assign isa.dispatch_done = dispatch_done;

    assign err_o       = err_q;
    assign mon_state_o = state_q;

    // A dispatch always offers its instruction to exactly one engine
    a_vld_onehot: assert property (
        @(posedge clk) disable iff (reset_i)
        (state_q == ST_DISPATCH) |-> $onehot(cfg_vld_o)
    );

    // A pending valid holds until its engine takes it
    a_vld_hold: assert property (
        @(posedge clk) disable iff (reset_i)
        (cfg_vld_o & ~cfg_rdy_i) != '0 |=> cfg_vld_o == $past(cfg_vld_o)
    );

endmodule

`default_nettype wire

//--- hdl/ccu_pkg.sv
// Shared definitions for the configuration control unit
// Widths, engine and bank counts, opcodes, beat lengths,
// global-buffer port indices and the instruction header layout

`default_nettype none

package ccu_pkg;

    // ============================================================
    // Widths and counts
    // ============================================================
    localparam int PORT_WIDTH   = 32;
    localparam int MAX_BEATS    = 4;
    localparam int CFG_WIDTH    = PORT_WIDTH * MAX_BEATS;
    localparam int NUM_ENGINE   = 3;
    localparam int NUM_BANK     = 4;
    localparam int NUM_GLB_PORT = 6;
    localparam int CNT_WIDTH    = 2;

    // Instruction lengths in beats
    localparam int GIC_BEATS = 2;
    localparam int FPS_BEATS = 4;
    localparam int KNN_BEATS = 2;

    // Global-buffer port map, write ports first
    localparam int PORT_GIC_WR = 0;
    localparam int PORT_FPS_WR = 1;
    localparam int PORT_KNN_WR = 2;
    localparam int PORT_GIC_RD = 3;
    localparam int PORT_FPS_RD = 4;
    localparam int PORT_KNN_RD = 5;

    // ============================================================
    // Instruction encoding
    // ============================================================
    typedef enum logic [1:0] {
        OP_GIC = 2'd0,
        OP_FPS = 2'd1,
        OP_KNN = 2'd2,
        OP_BAD = 2'd3
    } opcode_e;

    // Header view of the first beat, top bit first
    typedef struct packed {
        opcode_e                               opcode;
        logic                                  rd_off;
        logic                                  wr_off;
        logic [NUM_BANK-1:0]                   rd_bank;
        logic [NUM_BANK-1:0]                   wr_bank;
        logic [PORT_WIDTH-4-2*NUM_BANK-1:0]    reserved;
    } isa_header_t;

    typedef union packed {
        isa_header_t             hdr;
        logic [PORT_WIDTH-1:0]   raw;
    } isa_beat_u;

endpackage

`default_nettype wire

//--- hdl/ccu_top.sv
// Top level of the configuration control unit
// Host beat stream in, per-engine dispatch and port config out

`timescale 1ns/1ps
`default_nettype none

module ccu_top import ccu_pkg::*; #(
    parameter int GIC_LEN = GIC_BEATS,
    parameter int FPS_LEN = FPS_BEATS,
    parameter int KNN_LEN = KNN_BEATS,
    parameter int MAX_LEN = MAX_BEATS
) (
    input  logic                                  clk,
    input  logic                                  reset_i,
    input  logic [PORT_WIDTH-1:0]                 isa_dat_i,
    input  logic                                  isa_vld_i,
    input  logic                                  isa_last_i,
    output logic                                  isa_rdy_o,
    output logic [NUM_ENGINE-1:0]                 cfg_vld_o,
    input  logic [NUM_ENGINE-1:0]                 cfg_rdy_i,
    output logic [CFG_WIDTH-1:0]                  cfg_info_o,
    output logic [NUM_GLB_PORT-1:0][NUM_BANK-1:0] port_bank_flag_o,
    output logic [NUM_GLB_PORT-1:0]               port_off_o,
    output logic                                  err_o,
    output logic [1:0]                            mon_state_o
);

    logic                 cnt_clear;
    logic                 cnt_step;
    logic [CNT_WIDTH-1:0] beat_len;
    logic                 last_beat;
    opcode_e              target;

    isa_if isa_bus ();

    // ============================================================
    // Control
    // ============================================================
    ccu_fsm #(
        .GIC_LEN (GIC_LEN),
        .FPS_LEN (FPS_LEN),
        .KNN_LEN (KNN_LEN)
    ) ccu_fsm_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .isa_dat_i   (isa_dat_i),
        .isa_vld_i   (isa_vld_i),
        .isa_last_i  (isa_last_i),
        .isa_rdy_o   (isa_rdy_o),
        .cfg_vld_o   (cfg_vld_o),
        .cfg_rdy_i   (cfg_rdy_i),
        .last_beat_i (last_beat),
        .target_i    (target),
        .cnt_clear_o (cnt_clear),
        .cnt_step_o  (cnt_step),
        .beat_len_o  (beat_len),
        .err_o       (err_o),
        .mon_state_o (mon_state_o),
        .isa         (isa_bus.ctrl)
    );

    // Count is only consumed through last_beat_o
    beat_counter #(
        .MAX_LEN (MAX_LEN)
    ) beat_counter_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .clear_i     (cnt_clear),
        .step_i      (cnt_step),
        .len_i       (beat_len),
        .count_o     (),
        .last_beat_o (last_beat)
    );

    // ============================================================
    // Data
    // ============================================================
    isa_assembler isa_assembler_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .isa        (isa_bus.sink),
        .cfg_info_o (cfg_info_o),
        .target_o   (target)
    );

    glb_port_cfg #(
        .WR_IDX_GIC (PORT_GIC_WR),
        .WR_IDX_FPS (PORT_FPS_WR),
        .WR_IDX_KNN (PORT_KNN_WR),
        .RD_IDX_GIC (PORT_GIC_RD),
        .RD_IDX_FPS (PORT_FPS_RD),
        .RD_IDX_KNN (PORT_KNN_RD)
    ) glb_port_cfg_inst (
        .clk              (clk),
        .reset_i          (reset_i),
        .isa              (isa_bus.sink),
        .target_i         (target),
        .port_bank_flag_o (port_bank_flag_o),
        .port_off_o       (port_off_o)
    );

endmodule

`default_nettype wire

//--- hdl/glb_port_cfg.sv
// Global-buffer port configuration registers
// Bank flags and off-empty-full flags per port, loaded from the
// first-beat header of each dispatched instruction

`timescale 1ns/1ps
`default_nettype none

module glb_port_cfg import ccu_pkg::*; #(
    parameter int WR_IDX_GIC = PORT_GIC_WR,
    parameter int WR_IDX_FPS = PORT_FPS_WR,
    parameter int WR_IDX_KNN = PORT_KNN_WR,
    parameter int RD_IDX_GIC = PORT_GIC_RD,
    parameter int RD_IDX_FPS = PORT_FPS_RD,
    parameter int RD_IDX_KNN = PORT_KNN_RD
) (
    input  logic                                  clk,
    input  logic                                  reset_i,
    isa_if.sink                                   isa,
    input  opcode_e                               target_i,
    output logic [NUM_GLB_PORT-1:0][NUM_BANK-1:0] port_bank_flag_o,
    output logic [NUM_GLB_PORT-1:0]               port_off_o
);

    isa_header_t                       hdr_q;
    logic [NUM_GLB_PORT-1:0][NUM_BANK-1:0] bank_q;
    logic [NUM_GLB_PORT-1:0]           off_q;

    // Shadow of the header while the rest of the instruction arrives
    always_ff @(posedge clk) begin
        if (isa.accept && isa.first) begin
            hdr_q <= isa.beat.hdr;
        end
    end

    // ============================================================
    // Port update on dispatch
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset_i) begin
            bank_q <= '0;
            off_q  <= '0;
        end else if (isa.dispatch_done) begin
            case (target_i)
                OP_GIC: begin
                    bank_q[WR_IDX_GIC] <= hdr_q.wr_bank;
                    off_q[WR_IDX_GIC]  <= hdr_q.wr_off;
                    bank_q[RD_IDX_GIC] <= hdr_q.rd_bank;
                    off_q[RD_IDX_GIC]  <= hdr_q.rd_off;
                end
                OP_FPS: begin
                    bank_q[WR_IDX_FPS] <= hdr_q.wr_bank;
                    off_q[WR_IDX_FPS]  <= hdr_q.wr_off;
                    bank_q[RD_IDX_FPS] <= hdr_q.rd_bank;
                    off_q[RD_IDX_FPS]  <= hdr_q.rd_off;
                end
                OP_KNN: begin
                    bank_q[WR_IDX_KNN] <= hdr_q.wr_bank;
                    off_q[WR_IDX_KNN]  <= hdr_q.wr_off;
                    bank_q[RD_IDX_KNN] <= hdr_q.rd_bank;
                    off_q[RD_IDX_KNN]  <= hdr_q.rd_off;
                end
                default: begin
                    bank_q <= bank_q;
                end
            endcase
        end
    end

    assign port_bank_flag_o = bank_q;
    assign port_off_o       = off_q;

endmodule

`default_nettype wire

//--- hdl/isa_assembler.sv
// Instruction assembler
// Fills the wide configuration word from accepted beats, first
// beat in the top word, and latches the target opcode

`timescale 1ns/1ps
`default_nettype none

module isa_assembler import ccu_pkg::*; (
    input  logic                 clk,
    input  logic                 reset_i,
    isa_if.sink                  isa,
    output logic [CFG_WIDTH-1:0] cfg_info_o,
    output opcode_e              target_o
);

    logic [CFG_WIDTH-1:0] cfg_info_q;
    // Word slot for the next beat, counted from the top
    logic [CNT_WIDTH-1:0] slot_q;
    opcode_e              target_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            slot_q   <= '0;
            target_q <= OP_GIC;
        end else if (isa.accept) begin
            if (isa.first) begin
                slot_q   <= CNT_WIDTH'(1);
                target_q <= isa.beat.hdr.opcode;
            end else begin
                slot_q <= slot_q + CNT_WIDTH'(1);
            end
        end
    end

    // A new first beat also clears the lower words
    always_ff @(posedge clk) begin
        if (isa.accept) begin
            if (isa.first) begin
                cfg_info_q <= {isa.beat.raw, {(CFG_WIDTH-PORT_WIDTH){1'b0}}};
            end else begin
                cfg_info_q[CFG_WIDTH-1-PORT_WIDTH*int'(slot_q) -: PORT_WIDTH]
                    <= isa.beat.raw;
            end
        end
    end

    assign cfg_info_o = cfg_info_q;
    assign target_o   = target_q;

endmodule

`default_nettype wire

//--- hdl/isa_if.sv
// Interface for one accepted instruction beat
// Carries the accept and first-beat strobes, the beat itself
// and the engine dispatch strobe

`timescale 1ns/1ps
`default_nettype none

interface isa_if import ccu_pkg::*; ();

    // High for one cycle when the host beat is taken
    logic        accept;
    // First beat of an instruction, header view is valid
    logic        first;
    isa_beat_u   beat;
    // Engine handshake completed this cycle
    logic        dispatch_done;

    modport ctrl (
        output accept,
        output first,
        output beat,
        output dispatch_done
    );

    modport sink (
        input accept,
        input first,
        input beat,
        input dispatch_done
    );

endinterface

`default_nettype wire

//--- list.f
hdl/ccu_pkg.sv
hdl/isa_if.sv
hdl/beat_counter.sv
hdl/ccu_fsm.sv
hdl/isa_assembler.sv
hdl/glb_port_cfg.sv
hdl/ccu_top.sv
testbench/tb_ccu.sv

//--- run.sh
#!/bin/sh
# Build and run the configuration control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_ccu -o tb_ccu -f list.f

./obj_dir/tb_ccu > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi

//--- testbench/ccu_stim.txt
# kind word a b: T test-id 0 0 | R 0 0 0 reset | B beat-data(hex) last 0
# D engine(3 = none) expected-err ready-stall(255 = random)
T 6 0 0
R 0 0 0
T 1 0 0
B 65A12345 0 0
B DEADBEEF 0 0
B 0BADF00D 0 0
B C0FFEE01 1 0
D 1 0 0
T 2 0 0
B 13C00ABC 0 0
B 00000001 1 0
D 0 0 0
B B81FFFFF 0 0
B 76543210 1 0
D 2 0 0
T 3 0 0
B 8F600000 0 0
B A5A5A5A5 1 0
D 2 0 255
B 51200042 0 0
B 00000001 0 0
B 00000002 0 0
B 00000003 1 0
D 1 0 255
B 39600000 0 0
B FFFF0000 1 0
D 0 0 0
T 4 0 0
B 0AB00000 0 0
B 00000002 0 0
B 00000003 1 0
D 3 1 0
T 5 0 0
R 0 0 0
B F0000000 0 0
B 00000001 0 0
B 00000002 1 0
D 3 1 0
B 26700000 0 0
B 00000003 1 0
D 0 1 0

//--- testbench/tb_ccu.sv
// Testbench for the configuration control unit
// Reads beats and expected outcomes from the stimulus file, drives the
// host stream and checks dispatch, port config, errors and reset state

`timescale 1ns/1ps
`default_nettype none

module tb_ccu import ccu_pkg::*; ();

    localparam int CLK_PERIOD   = 10;
    localparam int BANK_VEC_W   = NUM_GLB_PORT * NUM_BANK;
    localparam int RANDOM_STALL = 255;

    logic                                  clk;
    logic                                  reset_i;
    logic [PORT_WIDTH-1:0]                 isa_dat_i;
    logic                                  isa_vld_i;
    logic                                  isa_last_i;
    logic                                  isa_rdy_o;
    logic [NUM_ENGINE-1:0]                 cfg_vld_o;
    logic [NUM_ENGINE-1:0]                 cfg_rdy_i;
    logic [CFG_WIDTH-1:0]                  cfg_info_o;
    logic [NUM_GLB_PORT-1:0][NUM_BANK-1:0] port_bank_flag_o;
    logic [NUM_GLB_PORT-1:0]               port_off_o;
    logic                                  err_o;
    logic [1:0]                            mon_state_o;

    // Stimulus records, one entry per file line
    logic [7:0]  kind_q[$];
    logic [31:0] word_q[$];
    int          arg_a_q[$];
    int          arg_b_q[$];
    int          beat_total;
    logic        stim_loaded;

    int          total_errors;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    int          cur_test;
    logic [31:0] rng_state;

    // Expected state of the DUT
    logic [CFG_WIDTH-1:0]    exp_info;
    logic [PORT_WIDTH-1:0]   hdr_word;
    int                      beat_idx;
    logic                    in_instr;
    logic [BANK_VEC_W-1:0]   exp_bank;
    logic [NUM_GLB_PORT-1:0] exp_off;

    ccu_top ccu_top_inst (
        .clk              (clk),
        .reset_i          (reset_i),
        .isa_dat_i        (isa_dat_i),
        .isa_vld_i        (isa_vld_i),
        .isa_last_i       (isa_last_i),
        .isa_rdy_o        (isa_rdy_o),
        .cfg_vld_o        (cfg_vld_o),
        .cfg_rdy_i        (cfg_rdy_i),
        .cfg_info_o       (cfg_info_o),
        .port_bank_flag_o (port_bank_flag_o),
        .port_off_o       (port_off_o),
        .err_o            (err_o),
        .mon_state_o      (mon_state_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ============================================================
    // Helpers
    // ============================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1:       return "fps dispatch";
            2:       return "port decode";
            3:       return "back-pressure";
            4:       return "length error";
            5:       return "bad opcode";
            6:       return "reset state";
            default: return "unnamed";
        endcase
    endfunction

    // Bank flags of one port inside the flat port vector
    function automatic logic [BANK_VEC_W-1:0] put_bank(input logic [BANK_VEC_W-1:0] vec,
                                                       input int port,
                                                       input logic [NUM_BANK-1:0] bank);
        logic [BANK_VEC_W-1:0] mask;
        mask = BANK_VEC_W'({NUM_BANK{1'b1}}) << (NUM_BANK * port);
        return (vec & ~mask) | ((BANK_VEC_W'(bank) << (NUM_BANK * port)) & mask);
    endfunction

    function automatic logic [NUM_GLB_PORT-1:0] put_off(input logic [NUM_GLB_PORT-1:0] vec,
                                                        input int port, input logic flag);
        logic [NUM_GLB_PORT-1:0] mask;
        mask = NUM_GLB_PORT'(1) << port;
        return flag ? (vec | mask) : (vec & ~mask);
    endfunction

    task automatic check_value(input string name, input logic [CFG_WIDTH-1:0] actual,
                               input logic [CFG_WIDTH-1:0] expected);
        if (actual !== expected) begin
            $display("mismatch at time %0t: %s is %0h, expected %0h",
                     $time, name, actual, expected);
            total_errors++;
            test_errors++;
        end
    endtask

    task automatic load_stim(output logic ok);
        int          fd;
        int          n;
        string       line;
        logic [7:0]  kind;
        logic [31:0] word;
        int          a;
        int          b;
        fd = $fopen("testbench/ccu_stim.txt", "r");
        ok = (fd != 0);
        beat_total = 0;
        if (!ok) begin
            $display("cannot open stimulus file testbench/ccu_stim.txt");
            total_errors++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%c %h %d %d", kind, word, a, b);
                    if (n == 4) begin
                        kind_q.push_back(kind);
                        word_q.push_back(word);
                        arg_a_q.push_back(a);
                        arg_b_q.push_back(b);
                        if (kind == "B") begin
                            beat_total++;
                        end
                    end else begin
                        $display("malformed stimulus line: %s", line);
                        total_errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ============================================================
    // Stimulus tasks, all entered just after a falling edge
    // ============================================================
    task automatic apply_reset(input logic check);
        reset_i    = 1'b1;
        isa_vld_i  = 1'b0;
        isa_last_i = 1'b0;
        cfg_rdy_i  = '0;
        repeat (5) @(negedge clk);
        reset_i  = 1'b0;
        exp_bank = '0;
        exp_off  = '0;
        in_instr = 1'b0;
        @(negedge clk);
        if (check) begin
            check_value("cfg_vld_o", CFG_WIDTH'(cfg_vld_o), '0);
            check_value("isa_rdy_o", CFG_WIDTH'(isa_rdy_o), CFG_WIDTH'(1));
            check_value("err_o", CFG_WIDTH'(err_o), '0);
            check_value("port_bank_flag_o", CFG_WIDTH'(port_bank_flag_o), '0);
            check_value("port_off_o", CFG_WIDTH'(port_off_o), '0);
            check_value("mon_state_o", CFG_WIDTH'(mon_state_o), '0);
        end
    endtask

    task automatic send_beat(input logic [PORT_WIDTH-1:0] data, input logic last);
        isa_dat_i  = data;
        isa_vld_i  = 1'b1;
        isa_last_i = last;
        while (!isa_rdy_o) begin
            @(negedge clk);
        end
        // No engine is offered anything while beats are taken
        check_value("cfg_vld_o", CFG_WIDTH'(cfg_vld_o), '0);
        @(negedge clk);
        isa_vld_i  = 1'b0;
        isa_last_i = 1'b0;
        if (!in_instr) begin
            hdr_word = data;
            exp_info = {data, {(CFG_WIDTH - PORT_WIDTH){1'b0}}};
            beat_idx = 1;
            in_instr = 1'b1;
        end else begin
            if (beat_idx < MAX_BEATS) begin
                exp_info = exp_info
                         | (CFG_WIDTH'(data) << (PORT_WIDTH * (MAX_BEATS - 1 - beat_idx)));
            end
            beat_idx++;
        end
    endtask

    task automatic check_offer(input logic [NUM_ENGINE-1:0] exp_vld);
        check_value("cfg_vld_o", CFG_WIDTH'(cfg_vld_o), CFG_WIDTH'(exp_vld));
        check_value("cfg_info_o", cfg_info_o, exp_info);
        check_value("isa_rdy_o", CFG_WIDTH'(isa_rdy_o), '0);
        // Port config waits for the dispatch edge
        check_value("port_bank_flag_o", CFG_WIDTH'(port_bank_flag_o), CFG_WIDTH'(exp_bank));
        check_value("port_off_o", CFG_WIDTH'(port_off_o), CFG_WIDTH'(exp_off));
    endtask

    task automatic finish_instr(input int eng, input int err, input int stall);
        logic [NUM_ENGINE-1:0] exp_vld;
        int                    wait_cycles;
        if (eng < NUM_ENGINE) begin
            exp_vld     = NUM_ENGINE'(1) << eng;
            wait_cycles = stall;
            if (stall == RANDOM_STALL) begin
                rng_state   = xorshift32(rng_state);
                wait_cycles = 1 + int'(rng_state % 32'd12);
            end
            check_offer(exp_vld);
            // Engine holds ready low
            repeat (wait_cycles) begin
                @(negedge clk);
                check_offer(exp_vld);
            end
            cfg_rdy_i = exp_vld;
            @(negedge clk);
            cfg_rdy_i = '0;
            exp_bank  = put_bank(exp_bank, PORT_GIC_WR + eng, hdr_word[23:20]);
            exp_bank  = put_bank(exp_bank, PORT_GIC_RD + eng, hdr_word[27:24]);
            exp_off   = put_off(exp_off, PORT_GIC_WR + eng, hdr_word[28]);
            exp_off   = put_off(exp_off, PORT_GIC_RD + eng, hdr_word[29]);
        end
        check_value("cfg_vld_o", CFG_WIDTH'(cfg_vld_o), '0);
        check_value("isa_rdy_o", CFG_WIDTH'(isa_rdy_o), CFG_WIDTH'(1));
        check_value("port_bank_flag_o", CFG_WIDTH'(port_bank_flag_o), CFG_WIDTH'(exp_bank));
        check_value("port_off_o", CFG_WIDTH'(port_off_o), CFG_WIDTH'(exp_off));
        check_value("err_o", CFG_WIDTH'(err_o), CFG_WIDTH'(err));
        in_instr = 1'b0;
    endtask

    task automatic close_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d %s: ok", cur_test, test_name(cur_test));
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", cur_test, test_name(cur_test), test_errors);
        end
        test_errors = 0;
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin : main
        logic ok;
        int   i;
        reset_i      = 1'b1;
        isa_dat_i    = '0;
        isa_vld_i    = 1'b0;
        isa_last_i   = 1'b0;
        cfg_rdy_i    = '0;
        total_errors = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        cur_test     = 0;
        in_instr     = 1'b0;
        exp_bank     = '0;
        exp_off      = '0;
        rng_state    = 32'h07f4_12aa;
        load_stim(ok);
        stim_loaded = 1'b1;
        if (ok) begin
            apply_reset(1'b0);
            for (i = 0; i < kind_q.size(); i++) begin
                case (kind_q[i])
                    "T": begin
                        if (cur_test != 0) begin
                            close_test();
                        end
                        cur_test    = int'(word_q[i]);
                        test_errors = 0;
                    end
                    "R": apply_reset(1'b1);
                    "B": send_beat(word_q[i], arg_a_q[i] != 0);
                    "D": finish_instr(int'(word_q[i]), arg_a_q[i], arg_b_q[i]);
                    default: begin
                        $display("unknown stimulus kind %c", kind_q[i]);
                        total_errors++;
                    end
                endcase
            end
            if (cur_test != 0) begin
                close_test();
            end
        end
        $display("passing tests: %0d, failing tests: %0d, total errors: %0d",
                 tests_passed, tests_failed, total_errors);
        if (total_errors == 0 && tests_failed == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Budget of 50 cycles per beat in the file
    initial begin : watchdog
        wait (stim_loaded === 1'b1);
        repeat ((beat_total + 2) * 50) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", (beat_total + 2) * 50);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
